/* include/cpu_defs.svh */
////////////////////////////////////////////////////////////////////////////
// cpu core constants
// reset vector, data width and register count
////////////////////////////////////////////////////////////////////////////

`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define CPU_RESET_PC 32'hBFC0_0000  // first fetch address
`define CPU_XLEN     32             // data path width
`define CPU_NREG     32             // gpr count, r0 included

`endif

/* hw/cpu_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// cpu core types
// opcode, funct and alu enums, control bundle and pipeline stage records
////////////////////////////////////////////////////////////////////////////

`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]         word_t;
    typedef logic [$clog2(`CPU_NREG)-1:0] reg_idx_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0D,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2A
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_LUI, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {BR_NONE, BR_BEQ, BR_BNE} branch_e;

    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    src_a_shamt;  // shift amount replaces rs
        logic    src_b_imm;    // immediate replaces rt
        logic    sign_ext;
        logic    reg_wr;
        logic    dst_rt;       // rt is the destination, else rd
        logic    mem_rd;
        logic    mem_wr;
        branch_e branch;
        logic    jump;
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    pc_plus4;
        word_t    bus_a;
        word_t    bus_b;
        word_t    imm32;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t dst;
        reg_idx_t shamt;
    } id_ex_t;

    typedef struct packed {
        logic     reg_wr;
        logic     mem_rd;
        logic     mem_wr;
        word_t    pc_plus4;
        word_t    alu_out;
        word_t    store_data;
        reg_idx_t dst;
    } ex_mem_t;

    typedef struct packed {
        logic     reg_wr;
        logic     mem_rd;
        word_t    pc_plus4;
        word_t    alu_out;
        reg_idx_t dst;
    } mem_wb_t;

endpackage

/* hw/decoder.sv */
////////////////////////////////////////////////////////////////////////////
// instruction decoder
// fills the control bundle and extends the 16-bit immediate
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module decoder import cpu_pkg::*; (
    input  word_t       instr_i,
    output ctrl_t       ctrl_o,
    output word_t       imm32_o,
    output logic [25:0] jump_target_o
);

    opcode_e op;
    funct_e  fn;

    assign op = opcode_e'(instr_i[31:26]);
    assign fn = funct_e'(instr_i[5:0]);

    always_comb begin
        ctrl_o        = '0;          // unknown encodings fall out as a nop
        ctrl_o.alu_op = ALU_PASS_B;
        ctrl_o.branch = BR_NONE;
        case (op)
            OP_SPECIAL: begin
                ctrl_o.reg_wr = 1'b1;
                case (fn)
                    FN_ADDU: ctrl_o.alu_op = ALU_ADD;
                    FN_SUBU: ctrl_o.alu_op = ALU_SUB;
                    FN_AND:  ctrl_o.alu_op = ALU_AND;
                    FN_OR:   ctrl_o.alu_op = ALU_OR;
                    FN_SLT:  ctrl_o.alu_op = ALU_SLT;
                    FN_SLL: begin
                        ctrl_o.alu_op      = ALU_SLL;
                        ctrl_o.src_a_shamt = 1'b1;
                    end
                    default: ctrl_o.reg_wr = 1'b0;
                endcase
            end
            OP_ADDIU, OP_LW: begin
                ctrl_o.alu_op    = ALU_ADD;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.sign_ext  = 1'b1;
                ctrl_o.reg_wr    = 1'b1;
                ctrl_o.dst_rt    = 1'b1;
                ctrl_o.mem_rd    = (op == OP_LW);
            end
            OP_ORI, OP_LUI: begin
                ctrl_o.alu_op    = (op == OP_ORI) ? ALU_OR : ALU_LUI;
                ctrl_o.src_b_imm = 1'b1;  // zero extended
                ctrl_o.reg_wr    = 1'b1;
                ctrl_o.dst_rt    = 1'b1;
            end
            OP_SW: begin
                ctrl_o.alu_op    = ALU_ADD;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.sign_ext  = 1'b1;
                ctrl_o.mem_wr    = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl_o.alu_op   = ALU_SUB;
                ctrl_o.sign_ext = 1'b1;  // word offset
                ctrl_o.branch   = (op == OP_BEQ) ? BR_BEQ : BR_BNE;
            end
            OP_J:    ctrl_o.jump = 1'b1;
            default: ;
        endcase
    end

    assign imm32_o = ctrl_o.sign_ext ? {{16{instr_i[15]}}, instr_i[15:0]}
                                     : {16'h0000, instr_i[15:0]};
    assign jump_target_o = instr_i[25:0];

endmodule

/* hw/regfile.sv */
////////////////////////////////////////////////////////////////////////////
// general purpose register file
// two combinational reads, one write, r0 hard-wired to zero
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "cpu_defs.svh"

module regfile import cpu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     wr_en_i,
    input  reg_idx_t wr_addr_i,
    input  word_t    wr_data_i,
    input  reg_idx_t rs_i,
    input  reg_idx_t rt_i,
    output word_t    bus_a_o,
    output word_t    bus_b_o
);

    word_t regs_q [1:`CPU_NREG-1];
    logic  wr_live;

    assign wr_live = wr_en_i && (wr_addr_i != '0);  // writes to r0 are dropped

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < `CPU_NREG; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_live) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // same-cycle write shows through to decode
    assign bus_a_o = (rs_i == '0) ? '0 :
                     (wr_live && wr_addr_i == rs_i) ? wr_data_i : regs_q[rs_i];
    assign bus_b_o = (rt_i == '0) ? '0 :
                     (wr_live && wr_addr_i == rt_i) ? wr_data_i : regs_q[rt_i];

endmodule

/* hw/hazard_unit.sv */
////////////////////////////////////////////////////////////////////////////
// hazard unit
// execute-stage operand forwarding and load-use stall detection
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module hazard_unit import cpu_pkg::*; (
    input  reg_idx_t id_rs_i,
    input  reg_idx_t id_rt_i,
    input  id_ex_t   id_ex_i,
    input  ex_mem_t  ex_mem_i,
    input  mem_wb_t  mem_wb_i,
    output fwd_sel_e fwd_a_o,
    output fwd_sel_e fwd_b_o,
    output logic     stall_o,
    output logic     bubble_o
);

    // younger producer in MEM wins over WB
    function automatic fwd_sel_e fwd_pick(
        input reg_idx_t src,
        input ex_mem_t  em,
        input mem_wb_t  mw
    );
        fwd_sel_e sel;
        sel = FWD_REG;
        if (src != '0) begin
            if (em.reg_wr && em.dst == src)
                sel = FWD_MEM;
            else if (mw.reg_wr && mw.dst == src)
                sel = FWD_WB;
        end
        return sel;
    endfunction

    assign fwd_a_o = fwd_pick(id_ex_i.rs, ex_mem_i, mem_wb_i);
    assign fwd_b_o = fwd_pick(id_ex_i.rt, ex_mem_i, mem_wb_i);

    // load in EXE feeding the instruction in decode
    assign stall_o = id_ex_i.ctrl.mem_rd && (id_ex_i.dst != '0) &&
                     (id_ex_i.dst == id_rs_i || id_ex_i.dst == id_rt_i);

    // decode holds one cycle while a nop enters EXE
    assign bubble_o = stall_o;

endmodule

/* hw/alu.sv */
////////////////////////////////////////////////////////////////////////////
// integer alu
// arithmetic, logic, shift and lui, plus operand equality for branches
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module alu import cpu_pkg::*; (
    input  alu_op_e op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    output word_t   result_o,
    output logic    zero_o
);

    always_comb begin
        case (op_i)
            ALU_ADD:    result_o = a_i + b_i;
            ALU_SUB:    result_o = a_i - b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_OR:     result_o = a_i | b_i;
            ALU_SLT:    result_o = word_t'($signed(a_i) < $signed(b_i));
            ALU_SLL:    result_o = b_i << a_i[4:0];       // a carries shamt
            ALU_LUI:    result_o = {b_i[15:0], 16'h0000};
            default:    result_o = b_i;                   // pass b
        endcase
    end

    assign zero_o = (a_i == b_i);  // beq/bne compare

endmodule

/* hw/mycpu_top.sv */
////////////////////////////////////////////////////////////////////////////
// mips32 subset core, five-stage in-order pipeline
// sram-style instruction and data ports, write-back debug trace
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "cpu_defs.svh"

module mycpu_top import cpu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,
    // instruction sram with data one cycle after the address
    output logic       inst_sram_en_o,
    output word_t      inst_sram_addr_o,
    input  word_t      inst_sram_rdata_i,
    // data sram
    output logic       data_sram_en_o,
    output logic [3:0] data_sram_wen_o,
    output word_t      data_sram_addr_o,
    output word_t      data_sram_wdata_o,
    input  word_t      data_sram_rdata_i,
    // write-back trace
    output word_t      debug_wb_pc_o,
    output logic [3:0] debug_wb_rf_wen_o,
    output reg_idx_t   debug_wb_rf_wnum_o,
    output word_t      debug_wb_rf_wdata_o
);

    // fetch
    word_t       pc_q;             // pc of the word now on inst_sram_rdata_i
    word_t       npc;
    word_t       if_pc_plus4;
    logic        if_valid_q;       // low until the reset vector is requested
    logic        fetch_en;
    // decode
    word_t       if_id_instr_q;
    word_t       if_id_pc_plus4_q;
    ctrl_t       id_ctrl;
    word_t       id_imm32;
    logic [25:0] id_jtarget;
    reg_idx_t    id_rs;
    reg_idx_t    id_rt;
    reg_idx_t    id_rd;
    word_t       rf_bus_a;
    word_t       rf_bus_b;
    word_t       jump_addr;
    logic        stall;
    logic        bubble;
    id_ex_t      id_ex_d;
    id_ex_t      id_ex_q;
    // execute
    fwd_sel_e    fwd_a;
    fwd_sel_e    fwd_b;
    word_t       ex_op_a;
    word_t       ex_op_b;
    word_t       alu_a;
    word_t       alu_b;
    word_t       alu_result;
    logic        alu_zero;
    logic        br_taken;
    word_t       branch_addr;
    ex_mem_t     ex_mem_d;
    ex_mem_t     ex_mem_q;
    // memory and write-back
    word_t       mem_result;
    mem_wb_t     mem_wb_d;
    mem_wb_t     mem_wb_q;
    word_t       load_data_q;
    word_t       wb_result;

    // fetch and next pc
    assign fetch_en    = !stall;
    assign if_pc_plus4 = pc_q + 32'd4;
    assign jump_addr   = {if_id_pc_plus4_q[31:28], id_jtarget, 2'b00};
    assign branch_addr = id_ex_q.pc_plus4 + {id_ex_q.imm32[29:0], 2'b00};

    always_comb begin
        if (!if_valid_q)
            npc = pc_q;                  // first request is the reset vector
        else if (br_taken)
            npc = branch_addr;
        else if (id_ctrl.jump)
            npc = jump_addr;             // delay slot is already in IF
        else
            npc = if_pc_plus4;
    end

    assign inst_sram_en_o   = fetch_en;
    assign inst_sram_addr_o = npc;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q       <= `CPU_RESET_PC;
            if_valid_q <= 1'b0;
        end else if (fetch_en) begin
            pc_q       <= npc;
            if_valid_q <= 1'b1;
        end
    end

    // an all-zero IF/ID word decodes as a harmless nop
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            if_id_instr_q    <= '0;
            if_id_pc_plus4_q <= '0;
        end else if (br_taken) begin
            if_id_instr_q    <= '0;      // wrong-path fetch behind the delay slot
            if_id_pc_plus4_q <= '0;
        end else if (!stall) begin
            if_id_instr_q    <= if_valid_q ? inst_sram_rdata_i : '0;
            if_id_pc_plus4_q <= if_pc_plus4;
        end
    end

    // decode stage
    assign id_rs = if_id_instr_q[25:21];
    assign id_rt = if_id_instr_q[20:16];
    assign id_rd = if_id_instr_q[15:11];

    decoder u_decoder (
        .instr_i       (if_id_instr_q),
        .ctrl_o        (id_ctrl),
        .imm32_o       (id_imm32),
        .jump_target_o (id_jtarget)
    );

    regfile u_regfile (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .wr_en_i   (mem_wb_q.reg_wr),
        .wr_addr_i (mem_wb_q.dst),
        .wr_data_i (wb_result),
        .rs_i      (id_rs),
        .rt_i      (id_rt),
        .bus_a_o   (rf_bus_a),
        .bus_b_o   (rf_bus_b)
    );

    hazard_unit u_hazard (
        .id_rs_i  (id_rs),
        .id_rt_i  (id_rt),
        .id_ex_i  (id_ex_q),
        .ex_mem_i (ex_mem_q),
        .mem_wb_i (mem_wb_q),
        .fwd_a_o  (fwd_a),
        .fwd_b_o  (fwd_b),
        .stall_o  (stall),
        .bubble_o (bubble)
    );

    always_comb begin
        id_ex_d.ctrl     = id_ctrl;
        id_ex_d.pc_plus4 = if_id_pc_plus4_q;
        id_ex_d.bus_a    = rf_bus_a;
        id_ex_d.bus_b    = rf_bus_b;
        id_ex_d.imm32    = id_imm32;
        id_ex_d.rs       = id_rs;
        id_ex_d.rt       = id_rt;
        id_ex_d.dst      = id_ctrl.dst_rt ? id_rt : id_rd;
        id_ex_d.shamt    = if_id_instr_q[10:6];
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            id_ex_q <= '0;
        else if (bubble)
            id_ex_q <= '0;               // load-use slot
        else
            id_ex_q <= id_ex_d;
    end

    // execute stage
    function automatic word_t fwd_mux(
        input fwd_sel_e sel,
        input word_t    from_reg,
        input word_t    from_mem,
        input word_t    from_wb
    );
        case (sel)
            FWD_MEM: return from_mem;
            FWD_WB:  return from_wb;
            default: return from_reg;
        endcase
    endfunction

    assign ex_op_a = fwd_mux(fwd_a, id_ex_q.bus_a, mem_result, wb_result);
    assign ex_op_b = fwd_mux(fwd_b, id_ex_q.bus_b, mem_result, wb_result);
    assign alu_a   = id_ex_q.ctrl.src_a_shamt ? word_t'(id_ex_q.shamt) : ex_op_a;
    assign alu_b   = id_ex_q.ctrl.src_b_imm ? id_ex_q.imm32 : ex_op_b;

    alu u_alu (
        .op_i     (id_ex_q.ctrl.alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_result),
        .zero_o   (alu_zero)
    );

    assign br_taken = (id_ex_q.ctrl.branch == BR_BEQ &&  alu_zero) ||
                      (id_ex_q.ctrl.branch == BR_BNE && !alu_zero);

    always_comb begin
        ex_mem_d.reg_wr     = id_ex_q.ctrl.reg_wr;
        ex_mem_d.mem_rd     = id_ex_q.ctrl.mem_rd;
        ex_mem_d.mem_wr     = id_ex_q.ctrl.mem_wr;
        ex_mem_d.pc_plus4   = id_ex_q.pc_plus4;
        ex_mem_d.alu_out    = alu_result;
        ex_mem_d.store_data = ex_op_b;   // forwarded rt
        ex_mem_d.dst        = id_ex_q.dst;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            ex_mem_q <= '0;
        else
            ex_mem_q <= ex_mem_d;
    end

    // load issues from EXE, store from MEM; a load directly behind a store
    // shares the cycle with it and the store owns the port
    assign data_sram_en_o    = id_ex_q.ctrl.mem_rd || ex_mem_q.mem_wr;
    assign data_sram_wen_o   = ex_mem_q.mem_wr ? 4'b1111 : 4'b0000;
    assign data_sram_addr_o  = ex_mem_q.mem_wr ? ex_mem_q.alu_out : alu_result;
    assign data_sram_wdata_o = ex_mem_q.store_data;

    // load data is on the port while the load sits in MEM
    assign mem_result = ex_mem_q.mem_rd ? data_sram_rdata_i : ex_mem_q.alu_out;

    always_comb begin
        mem_wb_d.reg_wr   = ex_mem_q.reg_wr;
        mem_wb_d.mem_rd   = ex_mem_q.mem_rd;
        mem_wb_d.pc_plus4 = ex_mem_q.pc_plus4;
        mem_wb_d.alu_out  = ex_mem_q.alu_out;
        mem_wb_d.dst      = ex_mem_q.dst;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            mem_wb_q <= '0;
        else
            mem_wb_q <= mem_wb_d;
    end

    always_ff @(posedge clk) begin
        load_data_q <= data_sram_rdata_i;
    end

    // write-back stage
    assign wb_result = mem_wb_q.mem_rd ? load_data_q : mem_wb_q.alu_out;

    assign debug_wb_pc_o       = mem_wb_q.pc_plus4 - 32'd4;
    assign debug_wb_rf_wen_o   = (mem_wb_q.reg_wr && mem_wb_q.dst != '0) ? 4'b1111 : 4'b0000;
    assign debug_wb_rf_wnum_o  = mem_wb_q.dst;
    assign debug_wb_rf_wdata_o = wb_result;

endmodule

/* verification/mycpu_chk.sv */
////////////////////////////////////////////////////////////////////////////
// write-back trace and port protocol checker for the mips32 subset core
// holds the expected register trace of the test program
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "cpu_defs.svh"

module mycpu_chk import cpu_pkg::*; (
    input logic       clk,
    input logic       arst_n_i,
    input logic       inst_en_i,
    input word_t      inst_addr_i,
    input logic       data_en_i,
    input logic [3:0] data_wen_i,
    input word_t      wb_pc_i,
    input logic [3:0] wb_wen_i,
    input reg_idx_t   wb_wnum_i,
    input word_t      wb_wdata_i
);

    localparam int unsigned TRACE_LEN = 15;
    localparam int unsigned CHAIN_END = 5;                       // last entry of the alu chain
    localparam word_t       LOOP_PC   = `CPU_RESET_PC + 32'h58;  // final self-loop

    int unsigned fail_cnt = 0;
    int unsigned trace_idx;
    logic        trace_match;

    // expected {pc, register, value} in write-back order
    function automatic logic [68:0] trace_entry(input int unsigned idx);
        case (idx)
            0:       return {32'hBFC0_0000, 5'd1,  32'h1234_0000};  // lui
            1:       return {32'hBFC0_0004, 5'd1,  32'h1234_5678};  // ori with mem forward
            2:       return {32'hBFC0_0008, 5'd2,  32'h0000_0005};
            3:       return {32'hBFC0_000C, 5'd3,  32'h1234_567D};  // wb and mem forward
            4:       return {32'hBFC0_0010, 5'd4,  32'h1234_5678};
            5:       return {32'hBFC0_0014, 5'd5,  32'h0000_0050};  // sll by 4
            6:       return {32'hBFC0_001C, 5'd6,  32'hFFFF_FFFF};  // sign-extended imm
            7:       return {32'hBFC0_0020, 5'd7,  32'h1234_5678};  // load of the stored word
            8:       return {32'hBFC0_0024, 5'd8,  32'h1234_56C8};  // load-use consumer
            9:       return {32'hBFC0_0028, 5'd9,  32'h1234_56C8};
            10:      return {32'hBFC0_002C, 5'd10, 32'h0000_0001};  // slt -1 < 5
            11:      return {32'hBFC0_0034, 5'd11, 32'h0000_00AA};  // beq delay slot
            12:      return {32'hBFC0_0040, 5'd13, 32'h0000_00AB};  // bne fall-through
            13:      return {32'hBFC0_004C, 5'd14, 32'h0000_00FB};  // j delay slot
            14:      return {32'hBFC0_0054, 5'd16, 32'h1234_5778};  // j target
            default: return '0;
        endcase
    endfunction

    task automatic record_failure(input string what);
        fail_cnt++;
        $error("%s", what);
    endtask

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            trace_idx <= 0;
        else if (wb_wen_i == 4'hF)
            trace_idx <= trace_idx + 1;
    end

    always_comb begin
        trace_match = 1'b0;
        if (trace_idx < TRACE_LEN)
            trace_match = ({wb_pc_i, wb_wnum_i, wb_wdata_i} == trace_entry(trace_idx));
    end

    a_reset_quiet: assert property (@(posedge clk)
        !arst_n_i |-> wb_wen_i == 4'h0 && !data_en_i)
        else record_failure("trace or data port active during reset");

    a_first_fetch: assert property (@(posedge clk)
        $rose(arst_n_i) |-> inst_en_i && inst_addr_i == `CPU_RESET_PC &&
                            wb_wen_i == 4'h0 && !data_en_i)
        else record_failure("first fetch after reset is not the reset vector");

    a_trace: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_wen_i == 4'hF |-> trace_match)
        else record_failure("register write-back differs from the expected trace");

    // dependent alu results retire back to back
    a_alu_chain: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_wen_i == 4'hF && trace_idx < CHAIN_END |=> wb_wen_i == 4'hF)
        else record_failure("dependent alu chain lost a cycle before write-back");

    a_one_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
        !inst_en_i |=> inst_en_i)
        else record_failure("fetch held for more than one cycle");

    a_store_port: assert property (@(posedge clk) disable iff (!arst_n_i)
        data_wen_i != 4'h0 |-> data_wen_i == 4'hF && data_en_i)
        else record_failure("partial or unenabled store on the data port");

    a_no_r0: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_wen_i == 4'hF |-> wb_wnum_i != '0)
        else record_failure("write-back to register 0 was traced");

    a_trace_done: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_pc_i == LOOP_PC |-> trace_idx == TRACE_LEN)
        else record_failure("final loop reached before the whole trace was seen");

endmodule

/* verification/tb_mycpu_top.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the mips32 subset core
// instruction rom and data ram models, fixed program, final memory check
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "cpu_defs.svh"

module tb_mycpu_top import cpu_pkg::*; ();

    localparam word_t ROM_BASE       = `CPU_RESET_PC;
    localparam word_t LOOP_PC        = ROM_BASE + 32'h58;  // final self-loop
    localparam int    TIMEOUT_CYCLES = 200;
    localparam int    STORE_WORD     = 4;                  // byte address 0x10
    localparam word_t STORE_VALUE    = 32'h1234_5678;

    logic        clk;
    logic        arst_n;
    logic        inst_en;
    word_t       inst_addr;
    word_t       inst_rdata = '0;
    logic        data_en;
    logic [3:0]  data_wen;
    word_t       data_addr;
    word_t       data_wdata;
    word_t       data_rdata = '0;
    word_t       wb_pc;
    logic [3:0]  wb_wen;
    reg_idx_t    wb_wnum;
    word_t       wb_wdata;
    word_t       rom [64];
    word_t       ram [64];
    int unsigned tb_errors = 0;

    mycpu_top dut (
        .clk                 (clk),
        .arst_n_i            (arst_n),
        .inst_sram_en_o      (inst_en),
        .inst_sram_addr_o    (inst_addr),
        .inst_sram_rdata_i   (inst_rdata),
        .data_sram_en_o      (data_en),
        .data_sram_wen_o     (data_wen),
        .data_sram_addr_o    (data_addr),
        .data_sram_wdata_o   (data_wdata),
        .data_sram_rdata_i   (data_rdata),
        .debug_wb_pc_o       (wb_pc),
        .debug_wb_rf_wen_o   (wb_wen),
        .debug_wb_rf_wnum_o  (wb_wnum),
        .debug_wb_rf_wdata_o (wb_wdata)
    );

    bind mycpu_top mycpu_chk u_chk (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .inst_en_i   (inst_sram_en_o),
        .inst_addr_i (inst_sram_addr_o),
        .data_en_i   (data_sram_en_o),
        .data_wen_i  (data_sram_wen_o),
        .wb_pc_i     (debug_wb_pc_o),
        .wb_wen_i    (debug_wb_rf_wen_o),
        .wb_wnum_i   (debug_wb_rf_wnum_o),
        .wb_wdata_i  (debug_wb_rf_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t r_type(input funct_e fn, input int rs, input int rt,
                                     input int rd, input int sh);
        return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic word_t i_type(input opcode_e op, input int rs, input int rt,
                                     input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic word_t j_type(input word_t target);
        return {OP_J, target[27:2]};
    endfunction

    task automatic load_memories();
        for (int i = 0; i < 64; i++) begin
            rom[i] = '0;                          // nop
            ram[i] = 32'hD0D0_0000 | i;
        end
        rom[0]  = i_type(OP_LUI,   0, 1,  16'h1234);
        rom[1]  = i_type(OP_ORI,   1, 1,  16'h5678);
        rom[2]  = i_type(OP_ADDIU, 0, 2,  16'h0005);
        rom[3]  = r_type(FN_ADDU,  1, 2, 3, 0);
        rom[4]  = r_type(FN_SUBU,  3, 2, 4, 0);
        rom[5]  = r_type(FN_SLL,   0, 2, 5, 4);
        rom[6]  = i_type(OP_SW,    0, 4,  16'h0010);
        rom[7]  = i_type(OP_ADDIU, 0, 6,  16'hFFFF);  // keeps the store off the load slot
        rom[8]  = i_type(OP_LW,    0, 7,  16'h0010);
        rom[9]  = r_type(FN_ADDU,  7, 5, 8, 0);       // load-use
        rom[10] = r_type(FN_AND,   6, 8, 9, 0);
        rom[11] = r_type(FN_SLT,   6, 2, 10, 0);
        rom[12] = i_type(OP_BEQ,   1, 4,  16'h0002);  // taken to 15
        rom[13] = i_type(OP_ORI,   0, 11, 16'h00AA);
        rom[14] = i_type(OP_ADDIU, 0, 12, 16'h0BAD);  // flushed
        rom[15] = i_type(OP_BNE,   9, 8,  16'h0004);  // not taken
        rom[16] = r_type(FN_ADDU,  11, 10, 13, 0);
        rom[17] = i_type(OP_ADDIU, 0, 0,  16'h0007);  // r0 target
        rom[18] = j_type(ROM_BASE + 32'h54);
        rom[19] = r_type(FN_OR,    13, 5, 14, 0);     // delay slot
        rom[20] = i_type(OP_ADDIU, 0, 15, 16'h0BAD);  // jumped over
        rom[21] = r_type(FN_ADDU,  14, 3, 16, 0);
        rom[22] = j_type(LOOP_PC);
    endtask

    // instruction rom with one-cycle read
    always @(posedge clk) begin
        if (arst_n && inst_en && inst_addr[31:8] != ROM_BASE[31:8]) begin
            $display("FAIL @%0t: fetch address 0x%08h outside the instruction ROM",
                     $time, inst_addr);
            tb_errors++;
        end
        if (inst_en)
            inst_rdata <= rom[inst_addr[7:2]];
    end

    // data ram with one-cycle read
    always @(posedge clk) begin
        if (data_en) begin
            if (data_wen == 4'b1111)
                ram[data_addr[7:2]] <= data_wdata;
            else
                data_rdata <= ram[data_addr[7:2]];
        end
    end

    initial begin : main
        logic reached;
        arst_n  = 1'b0;
        reached = 1'b0;
        load_memories();
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        for (int cyc = 0; cyc < TIMEOUT_CYCLES && !reached; cyc++) begin
            @(negedge clk);
            if (wb_pc == LOOP_PC)
                reached = 1'b1;
        end
        if (!reached) begin
            $display("timeout: the core did not reach the final loop within %0d cycles",
                     TIMEOUT_CYCLES);
            tb_errors++;
        end else begin
            repeat (2) @(posedge clk);            // let the last assertions fire
            if (ram[STORE_WORD] !== STORE_VALUE) begin
                $display("FAIL @%0t: stored word is 0x%08h, expected 0x%08h",
                         $time, ram[STORE_WORD], STORE_VALUE);
                tb_errors++;
            end
        end
        $display("errors: %0d testbench, %0d assertion", tb_errors, dut.u_chk.fail_cnt);
        if (tb_errors == 0 && dut.u_chk.fail_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

/* list.f */
+incdir+include
hw/cpu_pkg.sv
hw/decoder.sv
hw/regfile.sv
hw/hazard_unit.sv
hw/alu.sv
hw/mycpu_top.sv
verification/mycpu_chk.sv
verification/tb_mycpu_top.sv
